// File: filelist.f
+incdir+common
common/sched_pkg.sv
slot_pool/slot_keeper.sv
logic/max_slot_finder.sv
slot_pool/slot_pool.sv
ingress/port_tagger.sv
ingress/rx_dispatch.sv
logic/packet_scheduler.sv
bench/scheduler_props.sv
bench/scheduler_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= scheduler_tb
RTL_TOP    ?= packet_scheduler
FILELIST   ?= filelist.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing --assert -Wall

.PHONY: all run build lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: bench/scheduler_tb.sv
`timescale 1ns/1ps
`include "sched_settings.svh"

`default_nettype none

module scheduler_tb
  import sched_pkg::*;
();

  localparam int CLK_PERIOD  = 100;
  localparam int RST_CYCLES  = 16;
  localparam int N_PKTS      = 60;
  localparam int MAX_LEN     = 6;
  localparam int DRAIN_LIMIT = N_PKTS * (MAX_LEN * 4 + 10);
  localparam int TIMEOUT_NS  = (RST_CYCLES + 200 + 2 * DRAIN_LIMIT) * CLK_PERIOD;
  // Leaves out core 5, the one with the most slots, and core 0
  localparam logic [`SCHED_CORES-1:0] CORE_MASK = 'hde;

  logic                    clk = 1'b0;
  logic                    rst_r;
  rx_beat_t                rx_beat    [`SCHED_PORTS];
  logic [`SCHED_PORTS-1:0] rx_valid;
  logic [`SCHED_PORTS-1:0] rx_ready;
  core_beat_t              core_beat  [`SCHED_PORTS];
  logic [`SCHED_PORTS-1:0] core_valid;
  logic [`SCHED_PORTS-1:0] core_ready;
  ctrl_msg_t               ctrl_msg;
  logic                    ctrl_valid;
  logic [`SCHED_CORES-1:0] income_cores;

  // Reference model state
  bit        free_slot  [`SCHED_CORES][`SCHED_SLOTS+1];
  int        init_cnt   [`SCHED_CORES];
  int        pick_cnt   [`SCHED_CORES];
  rx_beat_t  sent_q     [`SCHED_PORTS][$];
  ctrl_msg_t ctrl_q     [$];
  desc_t     cur_desc   [`SCHED_PORTS];
  bit        in_pkt     [`SCHED_PORTS];
  int        beats_left [`SCHED_PORTS];
  int        pkts_sent  [`SCHED_PORTS];
  desc_t     first_desc [`SCHED_PORTS];
  bit        first_seen [`SCHED_PORTS];
  int        pkts_done;
  bit        traffic;

  packet_scheduler packet_scheduler_inst (
    .clk          (clk),
    .rst_r        (rst_r),
    .rx_beat      (rx_beat),
    .rx_valid     (rx_valid),
    .rx_ready     (rx_ready),
    .core_beat    (core_beat),
    .core_valid   (core_valid),
    .core_ready   (core_ready),
    .ctrl_msg     (ctrl_msg),
    .ctrl_valid   (ctrl_valid),
    .income_cores (income_cores)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic stop_run();
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic fail_run(input string why);
    $display("ERROR: %s", why);
    stop_run();
  endtask

  task automatic check_value(input string test, input logic [127:0] exp,
                             input logic [127:0] act);
    assert (exp === act) else begin
      $display("CHECK FAILED: %s expected %0h actual %0h", test, exp, act);
      stop_run();
    end
  endtask

  task automatic check_true(input string test, input bit cond, input string why);
    assert (cond) else begin
      $display("ERROR in %s: %s", test, why);
      stop_run();
    end
  endtask

  function automatic rx_beat_t random_beat(input bit last);
    rx_beat_t b;
    b.data = `SCHED_DATA_W'({$urandom, $urandom});
    b.keep = KEEP_W'($urandom);
    b.last = last;
    return b;
  endfunction

  // Most free slots among enabled cores, lowest index on a tie, slots handed out from 1 up
  function automatic desc_t model_pick();
    desc_t d;
    int    best;
    best = -1;
    for (int i = 0; i < `SCHED_CORES; i++) begin
      if (CORE_MASK[i] && pick_cnt[i] > 0 &&
          (best < 0 || pick_cnt[i] > pick_cnt[best])) begin
        best = i;
      end
    end
    d.core = core_t'(best);
    d.slot = slot_t'(init_cnt[best] - pick_cnt[best] + 1);
    pick_cnt[best]--;
    return d;
  endfunction

  always @(posedge clk) begin : stream_block
    core_beat_t got;
    rx_beat_t   nb;
    desc_t      d;
    ctrl_msg_t  ret;
    if (!rst_r) begin
      if (ctrl_q.size() > 0) begin
        ret = ctrl_q.pop_front();
        // A returned slot is free again once its message goes out
        if (ret.op == SLOT_RETURN) begin
          free_slot[ret.core][ret.slot] = 1'b1;
        end
        ctrl_msg   <= ret;
        ctrl_valid <= 1'b1;
      end else begin
        ctrl_valid <= 1'b0;
      end
      for (int p = 0; p < `SCHED_PORTS; p++) begin
        if (traffic) begin
          if (!core_ready[p]) begin
            check_true("back_pressure", !rx_ready[p], "rx_ready high while core_ready low");
          end
          if (core_valid[p] && core_ready[p]) begin
            got = core_beat[p];
            if (sent_q[p].size() == 0) begin
              fail_run($sformatf("unexpected output beat on port %0d", p));
            end
            nb = sent_q[p].pop_front();
            check_value("forwarding", nb, got.beat);
            check_value("port_field", p, got.port);
            if (!in_pkt[p]) begin
              d = got.desc;
              check_true("valid_slots", income_cores[d.core], "descriptor core outside mask");
              check_true("valid_slots", free_slot[d.core][d.slot], "descriptor slot not free");
              free_slot[d.core][d.slot] = 1'b0;
              cur_desc[p] = d;
              in_pkt[p]   = 1'b1;
              if (!first_seen[p]) begin
                first_desc[p] = d;
                first_seen[p] = 1'b1;
              end
            end else begin
              check_value("same_descriptor", cur_desc[p], got.desc);
            end
            if (got.beat.last) begin
              // Packet done, so its slot goes back to the core
              in_pkt[p] = 1'b0;
              pkts_done++;
              ret.op   = SLOT_RETURN;
              ret.core = cur_desc[p].core;
              ret.slot = cur_desc[p].slot;
              ctrl_q.push_back(ret);
            end
          end
          if (!rx_valid[p] || rx_ready[p]) begin
            if (beats_left[p] == 0 && pkts_sent[p] < N_PKTS) begin
              beats_left[p] = 1 + int'($urandom % MAX_LEN);
              pkts_sent[p]++;
            end
            if (beats_left[p] > 0 && ($urandom % 4) != 0) begin
              nb = random_beat(beats_left[p] == 1);
              sent_q[p].push_back(nb);
              rx_beat[p]  <= nb;
              rx_valid[p] <= 1'b1;
              beats_left[p]--;
            end else begin
              rx_valid[p] <= 1'b0;
            end
          end
          core_ready[p] <= (($urandom % 4) != 0);
        end
      end
    end
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    fail_run("watchdog expired before all packets were seen");
  end

  initial begin : main
    desc_t     exp_first;
    desc_t     exp_second;
    ctrl_msg_t msg;
    int        wait_cycles;
    void'($urandom(74288));
    rst_r        = 1'b1;
    rx_valid     = '0;
    core_ready   = '1;
    ctrl_valid   = 1'b0;
    ctrl_msg     = '0;
    income_cores = '0;
    traffic      = 1'b0;
    pkts_done    = 0;
    for (int p = 0; p < `SCHED_PORTS; p++) begin
      rx_beat[p]    = '0;
      in_pkt[p]     = 1'b0;
      beats_left[p] = 0;
      pkts_sent[p]  = 0;
      first_seen[p] = 1'b0;
    end
    repeat (RST_CYCLES) @(posedge clk);
    rst_r <= 1'b0;

    // Reset stall, offered beats must not move while keepers are empty
    for (int p = 0; p < `SCHED_PORTS; p++) begin
      rx_beat[p] <= random_beat(1'b1);
    end
    rx_valid <= '1;
    repeat (8) begin
      @(posedge clk);
      check_value("reset_stall", '0, rx_ready);
      check_value("reset_stall", '0, core_valid);
    end
    rx_valid <= '0;

    // Best-core choice, distinct counts per core
    for (int i = 0; i < `SCHED_CORES; i++) begin
      init_cnt[i] = ((i * 3) % `SCHED_SLOTS) + 1;
      pick_cnt[i] = init_cnt[i];
      for (int s = 0; s <= `SCHED_SLOTS; s++) begin
        free_slot[i][s] = (s >= 1) && (s <= init_cnt[i]);
      end
      msg.op   = SLOT_INIT;
      msg.core = core_t'(i);
      msg.slot = slot_t'(init_cnt[i]);
      ctrl_q.push_back(msg);
    end
    while (ctrl_q.size() > 0) @(posedge clk);
    repeat (3) @(posedge clk);
    income_cores <= CORE_MASK;
    traffic      <= 1'b1;
    exp_first  = model_pick();
    exp_second = model_pick();
    while (!(first_seen[0] && first_seen[1])) @(posedge clk);
    if (first_desc[0] === exp_first) begin
      check_value("best_core", exp_second, first_desc[1]);
    end else begin
      check_value("best_core", exp_first, first_desc[1]);
      check_value("best_core", exp_second, first_desc[0]);
    end

    // Random traffic with back-pressure until every packet is out
    wait_cycles = 0;
    while (pkts_done < N_PKTS * `SCHED_PORTS) begin
      @(posedge clk);
      wait_cycles++;
      if (wait_cycles > 2 * DRAIN_LIMIT) begin
        fail_run($sformatf("missed packet, %0d of %0d packets seen",
                           pkts_done, N_PKTS * `SCHED_PORTS));
      end
    end
    for (int p = 0; p < `SCHED_PORTS; p++) begin
      check_value("no_lost_beats", 0, sent_q[p].size());
    end
    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/scheduler_props.sv
`timescale 1ns/1ps
`include "sched_settings.svh"

`default_nettype none

module scheduler_props
  import sched_pkg::*;
(
  input logic                    clk,
  input logic                    rst_r,
  input logic [`SCHED_PORTS-1:0] stalled,
  input logic [`SCHED_PORTS-1:0] waiting,
  input logic [`SCHED_PORTS-1:0] rx_ready,
  input logic [`SCHED_PORTS-1:0] core_valid,
  input logic [`SCHED_PORTS-1:0] core_ready,
  input core_beat_t              core_beat [`SCHED_PORTS],
  input logic [`SCHED_PORTS-1:0] grant,
  input logic                    pop
);

  for (genvar p = 0; p < `SCHED_PORTS; p++) begin : g_port
    assert property (@(posedge clk) disable iff (rst_r)
      stalled[p] |-> (!rx_ready[p] && !core_valid[p]))
      else $error("port %0d moves data while stalled", p);

    // Offered beat stays put until the core side takes it
    assert property (@(posedge clk) disable iff (rst_r)
      (core_valid[p] && !core_ready[p]) |=> (core_valid[p] && $stable(core_beat[p])))
      else $error("port %0d changed its beat under back-pressure", p);
  end

  // A pop serves one port, and that port has no unused descriptor
  assert property (@(posedge clk) disable iff (rst_r) pop |-> $onehot(grant & waiting))
    else $error("descriptor pop without exactly one waiting granted port");

endmodule

// Two taggers, one flag bit per tagger
bind packet_scheduler scheduler_props scheduler_props_inst (
  .clk        (clk),
  .rst_r      (rst_r),
  .stalled    ({rx_dispatch_inst.g_port[1].port_tagger_inst.state == sched_pkg::STALL,
                rx_dispatch_inst.g_port[0].port_tagger_inst.state == sched_pkg::STALL}),
  .waiting    ({(rx_dispatch_inst.g_port[1].port_tagger_inst.state == sched_pkg::STALL) ||
                (rx_dispatch_inst.g_port[1].port_tagger_inst.state == sched_pkg::WAIT),
                (rx_dispatch_inst.g_port[0].port_tagger_inst.state == sched_pkg::STALL) ||
                (rx_dispatch_inst.g_port[0].port_tagger_inst.state == sched_pkg::WAIT)}),
  .rx_ready   (rx_ready),
  .core_valid (core_valid),
  .core_ready (core_ready),
  .core_beat  (core_beat),
  .grant      (rx_dispatch_inst.grant),
  .pop        (pop)
);

`default_nettype wire

// File: logic/packet_scheduler.sv
`timescale 1ns/1ps
`include "sched_settings.svh"

`default_nettype none

module packet_scheduler
  import sched_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_r,

  // Ethernet receive side
  input  rx_beat_t                rx_beat    [`SCHED_PORTS],
  input  logic [`SCHED_PORTS-1:0] rx_valid,
  output logic [`SCHED_PORTS-1:0] rx_ready,

  // Tagged streams toward the cores
  output core_beat_t              core_beat  [`SCHED_PORTS],
  output logic [`SCHED_PORTS-1:0] core_valid,
  input  logic [`SCHED_PORTS-1:0] core_ready,

  // Slot messages from the cores
  input  ctrl_msg_t               ctrl_msg,
  input  logic                    ctrl_valid,

  input  logic [`SCHED_CORES-1:0] income_cores
);

  logic  pop;
  logic  pool_avail;
  desc_t pool_desc;

  slot_pool slot_pool_inst (
    .clk          (clk),
    .rst_r        (rst_r),
    .ctrl_msg     (ctrl_msg),
    .ctrl_valid   (ctrl_valid),
    .income_cores (income_cores),
    .pop          (pop),
    .pool_desc    (pool_desc),
    .pool_avail   (pool_avail)
  );

  rx_dispatch rx_dispatch_inst (
    .clk        (clk),
    .rst_r      (rst_r),
    .rx_beat    (rx_beat),
    .rx_valid   (rx_valid),
    .rx_ready   (rx_ready),
    .core_beat  (core_beat),
    .core_valid (core_valid),
    .core_ready (core_ready),
    .pop        (pop),
    .pool_avail (pool_avail),
    .pool_desc  (pool_desc)
  );

endmodule

`default_nettype wire

// File: ingress/rx_dispatch.sv
`timescale 1ns/1ps
`include "sched_settings.svh"

`default_nettype none

module rx_dispatch
  import sched_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_r,

  input  rx_beat_t                rx_beat    [`SCHED_PORTS],
  input  logic [`SCHED_PORTS-1:0] rx_valid,
  output logic [`SCHED_PORTS-1:0] rx_ready,

  output core_beat_t              core_beat  [`SCHED_PORTS],
  output logic [`SCHED_PORTS-1:0] core_valid,
  input  logic [`SCHED_PORTS-1:0] core_ready,

  output logic                    pop,
  input  logic                    pool_avail,
  input  desc_t                   pool_desc
);

  logic [`SCHED_PORTS-1:0] desc_req;
  logic [`SCHED_PORTS-1:0] grant;
  logic [`SCHED_PORTS-1:0] load;
  port_t                   last_port;
  port_t                   pick;
  logic                    pick_valid;

  function automatic port_t rr_port(port_t base, int offset);
    return port_t'((int'(base) + offset) % `SCHED_PORTS);
  endfunction

  // Search starts right after the last grant, closest requester wins
  always_comb begin
    pick       = last_port;
    pick_valid = 1'b0;
    for (int i = `SCHED_PORTS; i >= 1; i--) begin
      if (desc_req[rr_port(last_port, i)]) begin
        pick       = rr_port(last_port, i);
        pick_valid = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      grant     <= '0;
      last_port <= port_t'(`SCHED_PORTS - 1);
    end else begin
      grant <= pick_valid ? (`SCHED_PORTS'(1) << pick) : '0;
      if (pick_valid) begin
        last_port <= pick;
      end
    end
  end

  assign pop  = |grant;
  assign load = grant & {`SCHED_PORTS{pool_avail}};

  for (genvar p = 0; p < `SCHED_PORTS; p++) begin : g_port
    port_tagger port_tagger_inst (
      .clk        (clk),
      .rst_r      (rst_r),
      .port_id    (port_t'(p)),
      .rx_beat    (rx_beat[p]),
      .rx_valid   (rx_valid[p]),
      .rx_ready   (rx_ready[p]),
      .core_beat  (core_beat[p]),
      .core_valid (core_valid[p]),
      .core_ready (core_ready[p]),
      .desc_req   (desc_req[p]),
      .grant      (grant[p]),
      .load       (load[p]),
      .new_desc   (pool_desc)
    );
  end

endmodule

`default_nettype wire

// File: ingress/port_tagger.sv
`timescale 1ns/1ps

`default_nettype none

module port_tagger
  import sched_pkg::*;
(
  input  logic       clk,
  input  logic       rst_r,

  input  port_t      port_id,

  input  rx_beat_t   rx_beat,
  input  logic       rx_valid,
  output logic       rx_ready,

  output core_beat_t core_beat,
  output logic       core_valid,
  input  logic       core_ready,

  output logic       desc_req,
  input  logic       grant,
  input  logic       load,
  input  desc_t      new_desc
);

  port_state_e state;
  port_state_e state_nxt;
  desc_t       next_desc;
  desc_t       cur_desc;
  logic        active;
  logic        moved;
  logic        moved_last;

  assign active     = (state != STALL);
  assign rx_ready   = core_ready && active;
  assign core_valid = rx_valid && active;
  assign moved      = rx_valid && rx_ready;
  assign moved_last = moved && rx_beat.last;

  assign core_beat.beat = rx_beat;
  // First beat goes out with the fresh descriptor, later beats with the latched one
  assign core_beat.desc = (state == FIRST) ? next_desc : cur_desc;
  assign core_beat.port = port_id;

  assign desc_req = !grant &&
                    ((state == STALL) || (state == WAIT) || ((state == FIRST) && moved));

  always_comb begin
    state_nxt = state;
    case (state)
      STALL: begin
        if (load) begin
          state_nxt = FIRST;
        end
      end
      FIRST: begin
        if (moved_last) begin
          state_nxt = STALL;
        end else if (moved) begin
          state_nxt = WAIT;
        end
      end
      WAIT: begin
        if (load && moved_last) begin
          state_nxt = FIRST;
        end else if (load) begin
          state_nxt = MID;
        end else if (moved_last) begin
          state_nxt = STALL;
        end
      end
      MID: begin
        if (moved_last) begin
          state_nxt = FIRST;
        end
      end
      default: state_nxt = STALL;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      state <= STALL;
    end else begin
      state <= state_nxt;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      next_desc <= new_desc;
    end
    if ((state == FIRST) && moved) begin
      cur_desc <= next_desc;
    end
  end

endmodule

`default_nettype wire

// File: slot_pool/slot_pool.sv
`timescale 1ns/1ps
`include "sched_settings.svh"

`default_nettype none

module slot_pool
  import sched_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_r,

  input  ctrl_msg_t               ctrl_msg,
  input  logic                    ctrl_valid,

  input  logic [`SCHED_CORES-1:0] income_cores,

  input  logic                    pop,
  output desc_t                   pool_desc,
  output logic                    pool_avail
);

  ctrl_msg_t               ctrl_q;
  logic                    ctrl_q_valid;

  logic [`SCHED_CORES-1:0] init_stb;
  logic [`SCHED_CORES-1:0] ret_stb;
  logic [`SCHED_CORES-1:0] enables;
  logic [`SCHED_CORES-1:0] pop_vec;

  slot_t                   counts [`SCHED_CORES];
  slot_t                   heads  [`SCHED_CORES];

  core_t                   best_core;
  logic                    found;

  always_ff @(posedge clk) begin
    if (rst_r) begin
      ctrl_q_valid <= 1'b0;
    end else begin
      ctrl_q_valid <= ctrl_valid;
    end
  end

  always_ff @(posedge clk) begin
    ctrl_q <= ctrl_msg;
  end

  // Opcode decode, unknown codes fall through with no strobe
  always_comb begin
    for (int i = 0; i < `SCHED_CORES; i++) begin
      init_stb[i] = ctrl_q_valid && (ctrl_q.op == SLOT_INIT) && (ctrl_q.core == core_t'(i));
      ret_stb[i]  = ctrl_q_valid && (ctrl_q.op == SLOT_RETURN) && (ctrl_q.core == core_t'(i));
      enables[i]  = income_cores[i] && (counts[i] != '0);
      pop_vec[i]  = pop && found && (best_core == core_t'(i));
    end
  end

  for (genvar i = 0; i < `SCHED_CORES; i++) begin : g_keeper
    slot_keeper slot_keeper_inst (
      .clk           (clk),
      .rst_r         (rst_r),
      .init_count    (ctrl_q.slot),
      .init_valid    (init_stb[i]),
      .slot_in       (ctrl_q.slot),
      .slot_in_valid (ret_stb[i]),
      .pop           (pop_vec[i]),
      .slot_out      (heads[i]),
      .slot_count    (counts[i])
    );
  end

  max_slot_finder max_slot_finder_inst (
    .counts    (counts),
    .enables   (enables),
    .best_core (best_core),
    .found     (found)
  );

  assign pool_avail     = found;
  assign pool_desc.core = best_core;
  assign pool_desc.slot = heads[best_core];

endmodule

`default_nettype wire

// File: logic/max_slot_finder.sv
`timescale 1ns/1ps
`include "sched_settings.svh"

`default_nettype none

module max_slot_finder
  import sched_pkg::*;
(
  input  slot_t                   counts [`SCHED_CORES],
  input  logic [`SCHED_CORES-1:0] enables,
  output core_t                   best_core,
  output logic                    found
);

  // Leaves padded up to a power of two, padding is never enabled
  localparam int LEAVES = 1 << $clog2(`SCHED_CORES);
  localparam int NODES  = 2 * LEAVES - 1;

  slot_t node_val [NODES];
  core_t node_idx [NODES];
  logic  node_en  [NODES];
  logic  take_right;

  always_comb begin
    for (int i = 0; i < LEAVES; i++) begin
      if (i < `SCHED_CORES) begin
        node_val[LEAVES-1+i] = counts[i];
        node_en[LEAVES-1+i]  = enables[i];
      end else begin
        node_val[LEAVES-1+i] = '0;
        node_en[LEAVES-1+i]  = 1'b0;
      end
      node_idx[LEAVES-1+i] = core_t'(i);
    end

    // Bottom up, left child always covers the lower core indices
    take_right = 1'b0;
    for (int k = LEAVES - 2; k >= 0; k--) begin
      take_right = node_en[2*k+2] &&
                   (!node_en[2*k+1] || (node_val[2*k+2] > node_val[2*k+1]));
      node_val[k] = take_right ? node_val[2*k+2] : node_val[2*k+1];
      node_idx[k] = take_right ? node_idx[2*k+2] : node_idx[2*k+1];
      node_en[k]  = node_en[2*k+1] || node_en[2*k+2];
    end
  end

  assign best_core = node_idx[0];
  assign found     = node_en[0];

endmodule

`default_nettype wire

// File: slot_pool/slot_keeper.sv
`timescale 1ns/1ps
`include "sched_settings.svh"

`default_nettype none

module slot_keeper
  import sched_pkg::*;
(
  input  logic  clk,
  input  logic  rst_r,

  input  slot_t init_count,
  input  logic  init_valid,

  input  slot_t slot_in,
  input  logic  slot_in_valid,

  input  logic  pop,
  output slot_t slot_out,
  output slot_t slot_count
);

  localparam int PTR_W = (`SCHED_SLOTS > 1) ? $clog2(`SCHED_SLOTS) : 1;

  typedef logic [PTR_W-1:0] ptr_t;

  slot_t mem [`SCHED_SLOTS];
  ptr_t  head;
  ptr_t  tail;
  slot_t count;
  logic  do_pop;
  logic  do_push;

  function automatic ptr_t ptr_inc(ptr_t p);
    if (p == ptr_t'(`SCHED_SLOTS - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  assign do_pop  = pop && (count != '0);
  // A full keeper only takes a slot when one leaves in the same cycle
  assign do_push = slot_in_valid && ((count != slot_t'(`SCHED_SLOTS)) || do_pop);

  always_ff @(posedge clk) begin
    if (rst_r) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else if (init_valid) begin
      head  <= '0;
      tail  <= (init_count == slot_t'(`SCHED_SLOTS)) ? '0 : init_count[PTR_W-1:0];
      count <= init_count;
    end else begin
      if (do_pop) begin
        head <= ptr_inc(head);
      end
      if (do_push) begin
        tail <= ptr_inc(tail);
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  // Init lays out slots 1..N from the start of the ring
  always_ff @(posedge clk) begin
    if (init_valid) begin
      for (int i = 0; i < `SCHED_SLOTS; i++) begin
        mem[i] <= slot_t'(i + 1);
      end
    end else if (do_push) begin
      mem[tail] <= slot_in;
    end
  end

  assign slot_out   = mem[head];
  assign slot_count = count;

endmodule

`default_nettype wire

// File: common/sched_pkg.sv
`include "sched_settings.svh"

`default_nettype none

package sched_pkg;

  localparam int PORT_W = (`SCHED_PORTS > 1) ? $clog2(`SCHED_PORTS) : 1;
  localparam int CORE_W = $clog2(`SCHED_CORES);
  // Slots start at 1, so one extra code is needed
  localparam int SLOT_W = $clog2(`SCHED_SLOTS + 1);
  localparam int KEEP_W = `SCHED_DATA_W / 8;

  typedef logic [CORE_W-1:0] core_t;
  typedef logic [SLOT_W-1:0] slot_t;
  typedef logic [PORT_W-1:0] port_t;

  typedef struct packed {
    core_t core;
    slot_t slot;
  } desc_t;

  typedef struct packed {
    logic [`SCHED_DATA_W-1:0] data;
    logic [KEEP_W-1:0]        keep;
    logic                     last;
  } rx_beat_t;

  typedef struct packed {
    rx_beat_t beat;
    desc_t    desc;
    port_t    port;
  } core_beat_t;

  typedef enum logic [3:0] {
    SLOT_RETURN = 4'd0,
    SLOT_INIT   = 4'd3
  } ctrl_op_e;

  // slot is a slot number for SLOT_RETURN and a count for SLOT_INIT
  typedef struct packed {
    ctrl_op_e op;
    core_t    core;
    slot_t    slot;
  } ctrl_msg_t;

  typedef enum logic [1:0] {
    STALL,
    FIRST,
    WAIT,
    MID
  } port_state_e;

endpackage

`default_nettype wire

// File: common/sched_settings.svh
`ifndef SCHED_SETTINGS_SVH
`define SCHED_SETTINGS_SVH

// Number of Ethernet receive ports
`define SCHED_PORTS 2

// Number of cores fed by the scheduler
`define SCHED_CORES 8

// Max receive slots a single core can own
`define SCHED_SLOTS 8

// Stream data width in bits
`define SCHED_DATA_W 64

`endif
